//--- common/dewall_pkg.sv
`default_nettype none

package dewall_pkg;

	// ==================== sizes
	localparam int NUM_BLOCKS = 15;
	localparam int BLOCK_SIZE = 16;  // pixels per block edge
	localparam int FIFO_DEPTH = 4;

	typedef logic [9:0]            coord_t;       // 640x480 screen position
	typedef logic [3:0]            block_idx_t;
	typedef logic [0:0]            ball_id_t;     // 0 = ball 1, 1 = ball 2
	typedef logic [NUM_BLOCKS-1:0] alive_mask_t;

	// ==================== block table
	// upper-left corners in table order
	localparam coord_t BLOCK_X_MIN [NUM_BLOCKS] = '{
		10'd288, 10'd288, 10'd288,           // top column
		10'd240, 10'd240, 10'd240, 10'd240,  // middle left
		10'd336, 10'd336, 10'd336, 10'd336,  // middle right
		10'd208, 10'd208, 10'd400, 10'd400   // bottom
	};

	localparam coord_t BLOCK_Y_MIN [NUM_BLOCKS] = '{
		10'd64,  10'd80,  10'd96,
		10'd224, 10'd240, 10'd256, 10'd272,
		10'd224, 10'd240, 10'd256, 10'd272,
		10'd304, 10'd320, 10'd352, 10'd368
	};

	// ==================== state machines
	typedef enum logic [1:0] {
		idle,
		compare,
		raise_req,
		wait_ack_drop
	} scan_state_e;

	typedef enum logic {
		wait_req,
		hold_ack
	} hs_state_e;

	// point inside the 16x16 square of block idx including its edges
	function automatic logic in_block(coord_t x, coord_t y, block_idx_t idx);
		coord_t x_max;
		coord_t y_max;
		x_max = BLOCK_X_MIN[idx] + coord_t'(BLOCK_SIZE - 1);
		y_max = BLOCK_Y_MIN[idx] + coord_t'(BLOCK_SIZE - 1);
		return (x >= BLOCK_X_MIN[idx]) && (x <= x_max) &&
			(y >= BLOCK_Y_MIN[idx]) && (y <= y_max);
	endfunction

endpackage

`default_nettype wire

//--- common/hit_event_if.sv
`timescale 1ns/1ps
`default_nettype none

// one destroyed-block candidate per four-phase transfer
interface hit_event_if;

	import dewall_pkg::*;

	logic       req;
	logic       ack;
	block_idx_t block;
	ball_id_t   ball;

	modport source (
		output req,
		output block,
		output ball,
		input  ack
	);

	modport sink (
		input  req,
		input  block,
		input  ball,
		output ack
	);

endinterface

`default_nettype wire

//--- dewall/impact_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module impact_scanner (
	input  wire logic               Clk,
	input  wire logic               rst_n,
	input  wire logic               frame_clk,
	input  wire logic               game_start_flag,
	input  wire dewall_pkg::coord_t ball1_x,
	input  wire dewall_pkg::coord_t ball1_y,
	input  wire dewall_pkg::coord_t ball2_x,
	input  wire dewall_pkg::coord_t ball2_y,
	input  wire logic               ball1_air,
	input  wire logic               ball2_air,
	hit_event_if.source             evt
);

	import dewall_pkg::*;

	logic [1:0]  frame_sync;
	logic        frame_prev;
	logic        frame_rise;
	logic        start;

	coord_t      lat_x   [2];
	coord_t      lat_y   [2];
	logic        lat_air [2];

	scan_state_e state;
	ball_id_t    ball_sel;
	block_idx_t  blk;
	logic        pair_hit;
	logic        last_pair;
	logic        step;

	// ==================== frame tick
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			frame_sync <= 2'b00;
			frame_prev <= 1'b0;
		end else begin
			frame_sync <= {frame_sync[0], frame_clk};
			frame_prev <= frame_sync[1];
		end
	end

	assign frame_rise = frame_sync[1] & ~frame_prev;
	assign start      = (state == idle) && frame_rise && game_start_flag;

	// ball snapshot for the whole scan
	always_ff @(posedge Clk) begin
		if (start) begin
			lat_x[0]   <= ball1_x;
			lat_y[0]   <= ball1_y;
			lat_air[0] <= ball1_air;
			lat_x[1]   <= ball2_x;
			lat_y[1]   <= ball2_y;
			lat_air[1] <= ball2_air;
		end
	end

	// ==================== pair walk
	assign pair_hit  = lat_air[ball_sel] && in_block(lat_x[ball_sel], lat_y[ball_sel], blk);
	assign last_pair = (blk == block_idx_t'(NUM_BLOCKS - 1)) && (ball_sel == ball_id_t'(1));
	assign step      = ((state == compare) && !pair_hit) ||
		((state == wait_ack_drop) && !evt.ack);

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			ball_sel <= '0;
			blk      <= '0;
		end else if (start) begin
			ball_sel <= '0;
			blk      <= '0;
		end else if (step) begin
			if (blk == block_idx_t'(NUM_BLOCKS - 1)) begin
				blk      <= '0;
				ball_sel <= ball_sel + 1'b1;
			end else begin
				blk <= blk + 1'b1;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			state   <= idle;
			evt.req <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (start)
						state <= compare;
				end
				compare: begin
					if (pair_hit)
						state <= raise_req;
					else
						state <= last_pair ? idle : compare;
				end
				raise_req: begin
					evt.req <= 1'b1;  // data was loaded one cycle earlier
					if (evt.req && evt.ack) begin
						evt.req <= 1'b0;
						state   <= wait_ack_drop;
					end
				end
				wait_ack_drop: begin
					if (!evt.ack)
						state <= last_pair ? idle : compare;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if ((state == compare) && pair_hit) begin
			evt.block <= blk;
			evt.ball  <= ball_sel;
		end
	end

	a_block_in_range: assert property (@(posedge Clk) disable iff (!rst_n)
		evt.req |-> (evt.block <= block_idx_t'(NUM_BLOCKS - 1)));

endmodule

`default_nettype wire

//--- dewall/hit_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module hit_event_fifo (
	input  wire logic   Clk,
	input  wire logic   rst_n,
	hit_event_if.sink   in_evt,
	hit_event_if.source out_evt
);

	import dewall_pkg::*;

	block_idx_t                    mem_block [FIFO_DEPTH];
	ball_id_t                      mem_ball  [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]   count;

	hs_state_e rx_state;
	logic      tx_wait_drop;  // ack of the last send still high
	logic      full;
	logic      empty;
	logic      push;
	logic      pop;

	assign full  = (count == FIFO_DEPTH);
	assign empty = (count == '0);
	assign push  = (rx_state == wait_req) && in_evt.req && !full;
	assign pop   = out_evt.req && out_evt.ack;

	// ==================== input side
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			rx_state   <= wait_req;
			in_evt.ack <= 1'b0;
		end else begin
			case (rx_state)
				wait_req: begin
					if (push) begin  // no space keeps ack low
						in_evt.ack <= 1'b1;
						rx_state   <= hold_ack;
					end
				end
				hold_ack: begin
					if (!in_evt.req) begin
						in_evt.ack <= 1'b0;
						rx_state   <= wait_req;
					end
				end
				default: rx_state <= wait_req;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (push) begin
			mem_block[wr_ptr] <= in_evt.block;
			mem_ball[wr_ptr]  <= in_evt.ball;
		end
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ==================== output side
	assign out_evt.block = mem_block[rd_ptr];
	assign out_evt.ball  = mem_ball[rd_ptr];

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			out_evt.req  <= 1'b0;
			tx_wait_drop <= 1'b0;
		end else if (pop) begin
			out_evt.req  <= 1'b0;
			tx_wait_drop <= 1'b1;
		end else if (tx_wait_drop) begin
			if (!out_evt.ack)
				tx_wait_drop <= 1'b0;
		end else if (!empty) begin
			out_evt.req <= 1'b1;
		end
	end

	a_count_bound: assert property (@(posedge Clk) disable iff (!rst_n)
		count <= FIFO_DEPTH);

	a_out_stable: assert property (@(posedge Clk) disable iff (!rst_n)
		out_evt.req && !out_evt.ack |=> $stable(out_evt.block) && $stable(out_evt.ball));

endmodule

`default_nettype wire

//--- dewall/block_state.sv
`timescale 1ns/1ps
`default_nettype none

module block_state (
	input  wire logic              Clk,
	input  wire logic              rst_n,
	input  wire logic              before_game_flag,
	hit_event_if.sink              evt,
	output dewall_pkg::alive_mask_t alive,
	output logic                   ball1_hit_dewall,
	output logic                   ball2_hit_dewall
);

	import dewall_pkg::*;

	hs_state_e  state;
	logic       take_q;      // event taken last cycle
	block_idx_t take_block;
	ball_id_t   take_ball;
	logic       destroy;

	// ==================== handshake
	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			state   <= wait_req;
			evt.ack <= 1'b0;
			take_q  <= 1'b0;
		end else begin
			take_q <= 1'b0;
			case (state)
				wait_req: begin
					if (evt.req) begin
						evt.ack <= 1'b1;
						take_q  <= !before_game_flag;  // dropped before the game
						state   <= hold_ack;
					end
				end
				hold_ack: begin
					if (!evt.req) begin
						evt.ack <= 1'b0;
						state   <= wait_req;
					end
				end
				default: state <= wait_req;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if ((state == wait_req) && evt.req) begin
			take_block <= evt.block;
			take_ball  <= evt.ball;
		end
	end

	// ==================== wall state
	// a block already down gives no second pulse
	assign destroy = take_q && alive[take_block] && !before_game_flag;

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			alive            <= '1;
			ball1_hit_dewall <= 1'b0;
			ball2_hit_dewall <= 1'b0;
		end else begin
			ball1_hit_dewall <= destroy && (take_ball == ball_id_t'(0));
			ball2_hit_dewall <= destroy && (take_ball == ball_id_t'(1));
			if (before_game_flag)
				alive <= '1;
			else if (destroy)
				alive[take_block] <= 1'b0;
		end
	end

	a_one_hit_per_cycle: assert property (@(posedge Clk) disable iff (!rst_n)
		!(ball1_hit_dewall && ball2_hit_dewall));

endmodule

`default_nettype wire

//--- logic/wall_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module wall_renderer (
	input  wire logic                    Clk,
	input  wire logic                    rst_n,
	input  wire logic                    game_start_flag,
	input  wire dewall_pkg::coord_t      draw_x,
	input  wire dewall_pkg::coord_t      draw_y,
	input  wire dewall_pkg::alive_mask_t alive,
	output logic                         is_dewall
);

	import dewall_pkg::*;

	logic beam_in_wall;

	// ==================== beam test
	always_comb begin
		beam_in_wall = 1'b0;
		for (int i = 0; i < NUM_BLOCKS; i++) begin
			if (alive[i] && in_block(draw_x, draw_y, block_idx_t'(i)))
				beam_in_wall = 1'b1;
		end
	end

	// one cycle behind the beam
	always_ff @(posedge Clk) begin
		if (!rst_n)
			is_dewall <= 1'b0;
		else
			is_dewall <= beam_in_wall & game_start_flag;  // wall hidden outside the game
	end

endmodule

`default_nettype wire

//--- dewall/dewall_field.sv
`timescale 1ns/1ps
`default_nettype none

module dewall_field (
	input  wire logic               Clk,
	input  wire logic               rst_n,
	input  wire logic               frame_clk,         // frame tick at about 60 Hz
	input  wire logic               game_start_flag,
	input  wire logic               before_game_flag,
	input  wire dewall_pkg::coord_t draw_x,
	input  wire dewall_pkg::coord_t draw_y,
	input  wire dewall_pkg::coord_t ball1_x,
	input  wire dewall_pkg::coord_t ball1_y,
	input  wire dewall_pkg::coord_t ball2_x,
	input  wire dewall_pkg::coord_t ball2_y,
	input  wire logic               ball1_air,
	input  wire logic               ball2_air,
	output logic                    is_dewall,
	output logic                    ball1_hit_dewall,
	output logic                    ball2_hit_dewall
);

	import dewall_pkg::*;

	alive_mask_t alive;

	hit_event_if scan_evt ();   // scanner to buffer
	hit_event_if store_evt ();  // buffer to block state

	impact_scanner u_impact_scanner (
		.Clk             (Clk),
		.rst_n           (rst_n),
		.frame_clk       (frame_clk),
		.game_start_flag (game_start_flag),
		.ball1_x         (ball1_x),
		.ball1_y         (ball1_y),
		.ball2_x         (ball2_x),
		.ball2_y         (ball2_y),
		.ball1_air       (ball1_air),
		.ball2_air       (ball2_air),
		.evt             (scan_evt.source)
	);

	hit_event_fifo u_hit_event_fifo (
		.Clk     (Clk),
		.rst_n   (rst_n),
		.in_evt  (scan_evt.sink),
		.out_evt (store_evt.source)
	);

	block_state u_block_state (
		.Clk              (Clk),
		.rst_n            (rst_n),
		.before_game_flag (before_game_flag),
		.evt              (store_evt.sink),
		.alive            (alive),
		.ball1_hit_dewall (ball1_hit_dewall),
		.ball2_hit_dewall (ball2_hit_dewall)
	);

	wall_renderer u_wall_renderer (
		.Clk             (Clk),
		.rst_n           (rst_n),
		.game_start_flag (game_start_flag),
		.draw_x          (draw_x),
		.draw_y          (draw_y),
		.alive           (alive),
		.is_dewall       (is_dewall)
	);

endmodule

`default_nettype wire

//--- sim/tb_dewall_checks.svh
`ifndef TB_DEWALL_CHECKS_SVH
`define TB_DEWALL_CHECKS_SVH

// ==================== block corners
localparam logic [9:0] tb_x_min [15] = '{
	10'd288, 10'd288, 10'd288,
	10'd240, 10'd240, 10'd240, 10'd240,
	10'd336, 10'd336, 10'd336, 10'd336,
	10'd208, 10'd208, 10'd400, 10'd400
};

localparam logic [9:0] tb_y_min [15] = '{
	10'd64,  10'd80,  10'd96,
	10'd224, 10'd240, 10'd256, 10'd272,
	10'd224, 10'd240, 10'd256, 10'd272,
	10'd304, 10'd320, 10'd352, 10'd368
};

// beam inside a standing block of the expected wall
function automatic logic pixel_in_wall(input logic [9:0] x, input logic [9:0] y);
	logic hit;
	hit = 1'b0;
	for (int b = 0; b < 15; b++) begin
		if (tb_alive[b] && x >= tb_x_min[b] && x < tb_x_min[b] + 16 &&
			y >= tb_y_min[b] && y < tb_y_min[b] + 16)
			hit = 1'b1;
	end
	return hit;
endfunction

// ==================== pixel probe
task automatic probe_pixel(input logic [9:0] x, input logic [9:0] y);
	logic want;
	want = game_start_flag && pixel_in_wall(x, y);
	@(posedge Clk);
	#1;
	draw_x = x;
	draw_y = y;
	@(posedge Clk);
	@(negedge Clk);  // is_dewall settled one cycle after the beam
	a_probe: assert (is_dewall === want) else begin
		$display("ERR is_dewall at (%0d,%0d): got %h expected %h", x, y, is_dewall, want);
		err_count++;
	end
endtask

task automatic check_hits(input int got1, input int got2, input int exp1, input int exp2);
	a_hit1_count: assert (got1 == exp1) else begin
		$display("ERR ball1_hit_dewall pulses: got %h expected %h", got1, exp1);
		err_count++;
	end
	a_hit2_count: assert (got2 == exp2) else begin
		$display("ERR ball2_hit_dewall pulses: got %h expected %h", got2, exp2);
		err_count++;
	end
endtask

// ==================== concurrent checks
a_reset_quiet: assert property (@(posedge Clk)
	!rst_n |=> (!is_dewall && !ball1_hit_dewall && !ball2_hit_dewall))
	else begin
		$display("outputs not low one cycle into reset");
		err_count++;
	end

a_hits_apart: assert property (@(posedge Clk) disable iff (!rst_n)
	!(ball1_hit_dewall && ball2_hit_dewall))
	else begin
		$display("ERR ball hits: ball1_hit_dewall %h ball2_hit_dewall %h", ball1_hit_dewall,
			ball2_hit_dewall);
		err_count++;
	end

a_hit1_short: assert property (@(posedge Clk) disable iff (!rst_n)
	ball1_hit_dewall |=> !ball1_hit_dewall)
	else begin
		$display("ball1_hit_dewall stayed high for more than one cycle");
		err_count++;
	end

a_hit2_short: assert property (@(posedge Clk) disable iff (!rst_n)
	ball2_hit_dewall |=> !ball2_hit_dewall)
	else begin
		$display("ball2_hit_dewall stayed high for more than one cycle");
		err_count++;
	end

a_no_hit_before_game: assert property (@(posedge Clk) disable iff (!rst_n)
	before_game_flag |=> (!ball1_hit_dewall && !ball2_hit_dewall))
	else begin
		$display("hit pulse while before_game_flag was high");
		err_count++;
	end

`endif

//--- sim/tb_dewall_field.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dewall_field;

	logic        Clk;
	logic        rst_n;
	logic        frame_clk;
	logic        game_start_flag;
	logic        before_game_flag;
	logic [9:0]  draw_x;
	logic [9:0]  draw_y;
	logic [9:0]  ball1_x;
	logic [9:0]  ball1_y;
	logic [9:0]  ball2_x;
	logic [9:0]  ball2_y;
	logic        ball1_air;
	logic        ball2_air;
	logic        is_dewall;
	logic        ball1_hit_dewall;
	logic        ball2_hit_dewall;

	logic [19:0] lfsr_state;
	logic [14:0] tb_alive;  // expected wall
	int          err_count;
	int          test_count;
	int          test_err_base;
	int          hit1_count;
	int          hit2_count;

	`include "tb_dewall_checks.svh"

	dewall_field u_dewall_field (
		.Clk              (Clk),
		.rst_n            (rst_n),
		.frame_clk        (frame_clk),
		.game_start_flag  (game_start_flag),
		.before_game_flag (before_game_flag),
		.draw_x           (draw_x),
		.draw_y           (draw_y),
		.ball1_x          (ball1_x),
		.ball1_y          (ball1_y),
		.ball2_x          (ball2_x),
		.ball2_y          (ball2_y),
		.ball1_air        (ball1_air),
		.ball2_air        (ball2_air),
		.is_dewall        (is_dewall),
		.ball1_hit_dewall (ball1_hit_dewall),
		.ball2_hit_dewall (ball2_hit_dewall)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		if (ball1_hit_dewall)
			hit1_count++;
		if (ball2_hit_dewall)
			hit2_count++;
	end

	// ==================== random numbers
	// x^20 + x^17 + 1
	function automatic logic [19:0] lfsr_step(input logic [19:0] s);
		return {s[18:0], s[19] ^ s[16]};
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	task automatic pick_standing(input int avoid, output int b);
		int v;
		take_bits(4, v);
		b = v % 15;
		for (int i = 0; i < 15; i++) begin
			if (!tb_alive[b] || b == avoid)
				b = (b + 1) % 15;
		end
	endtask

	task automatic random_spot(input int b, output logic [9:0] x, output logic [9:0] y);
		int dx;
		int dy;
		take_bits(4, dx);
		take_bits(4, dy);
		x = tb_x_min[b] + 10'(dx);
		y = tb_y_min[b] + 10'(dy);
	endtask

	// ==================== stimulus
	task automatic set_balls(input logic [9:0] x1, input logic [9:0] y1, input logic a1,
		input logic [9:0] x2, input logic [9:0] y2, input logic a2);
		@(posedge Clk);
		#1;
		ball1_x   = x1;
		ball1_y   = y1;
		ball1_air = a1;
		ball2_x   = x2;
		ball2_y   = y2;
		ball2_air = a2;
	endtask

	function automatic logic dut_quiet();
		return u_dewall_field.u_impact_scanner.state == dewall_pkg::idle &&
			!u_dewall_field.scan_evt.req && !u_dewall_field.scan_evt.ack &&
			!u_dewall_field.store_evt.req && !u_dewall_field.store_evt.ack &&
			u_dewall_field.u_hit_event_fifo.count == 0;
	endfunction

	task automatic pulse_frame();
		int n;
		int calm;
		@(posedge Clk);
		#1 frame_clk = 1'b1;
		n = 0;
		do begin
			@(negedge Clk);
			n++;
		end while (u_dewall_field.u_impact_scanner.state == dewall_pkg::idle && n < 2000);
		if (n >= 2000) begin
			$display("scan did not start within 2000 cycles of a frame tick");
			err_count++;
		end
		@(posedge Clk);
		#1 frame_clk = 1'b0;
		n = 0;
		calm = 0;
		while (calm < 3 && n < 2000) begin  // scan done and event path drained
			@(negedge Clk);
			calm = dut_quiet() ? calm + 1 : 0;
			n++;
		end
		if (calm < 3) begin
			$display("event path did not settle within 2000 cycles");
			err_count++;
		end
	endtask

	task automatic check_all_blocks();
		for (int b = 0; b < 15; b++) begin
			probe_pixel(tb_x_min[b], tb_y_min[b]);
			probe_pixel(tb_x_min[b] + 10'd15, tb_y_min[b] + 10'd15);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
		test_err_base = err_count;
	endtask

	// ==================== tests
	initial begin
		int b1;
		int b2;
		int b3;
		int b4;
		int base1;
		int base2;
		logic [9:0] x1;
		logic [9:0] y1;
		logic [9:0] x2;
		logic [9:0] y2;
		rst_n = 1'b0;
		frame_clk = 1'b0;
		game_start_flag = 1'b0;
		before_game_flag = 1'b0;
		draw_x = '0;
		draw_y = '0;
		ball1_x = '0;
		ball1_y = '0;
		ball2_x = '0;
		ball2_y = '0;
		ball1_air = 1'b0;
		ball2_air = 1'b0;
		lfsr_state = 20'd69574;
		tb_alive = '1;
		err_count = 0;
		test_count = 0;
		test_err_base = 0;
		hit1_count = 0;
		hit2_count = 0;
		repeat (16) @(posedge Clk);
		#1 rst_n = 1'b1;

		@(posedge Clk);
		#1 game_start_flag = 1'b1;
		check_all_blocks();
		probe_pixel(10'd0, 10'd0);
		probe_pixel(10'd287, 10'd64);
		probe_pixel(10'd304, 10'd64);
		probe_pixel(10'd639, 10'd479);
		@(posedge Clk);
		#1 game_start_flag = 1'b0;
		check_all_blocks();  // wall hidden
		@(posedge Clk);
		#1 game_start_flag = 1'b1;
		end_test("pixel map after reset");

		pick_standing(-1, b1);
		random_spot(b1, x1, y1);
		base1 = hit1_count;
		base2 = hit2_count;
		set_balls(x1, y1, 1'b1, 10'd0, 10'd0, 1'b0);
		pulse_frame();
		check_hits(hit1_count - base1, hit2_count - base2, 1, 0);
		tb_alive[b1] = 1'b0;
		check_all_blocks();
		end_test("ball 1 destroys a block");

		base1 = hit1_count;
		base2 = hit2_count;
		pulse_frame();
		pulse_frame();
		check_hits(hit1_count - base1, hit2_count - base2, 0, 0);
		end_test("no second hit on a destroyed block");

		pick_standing(-1, b2);
		random_spot(b2, x2, y2);
		base1 = hit1_count;
		base2 = hit2_count;
		set_balls(x1, y1, 1'b0, x2, y2, 1'b0);
		pulse_frame();
		check_hits(hit1_count - base1, hit2_count - base2, 0, 0);
		probe_pixel(tb_x_min[b2], tb_y_min[b2]);
		set_balls(x1, y1, 1'b0, x2, y2, 1'b1);
		pulse_frame();
		check_hits(hit1_count - base1, hit2_count - base2, 0, 1);
		tb_alive[b2] = 1'b0;
		check_all_blocks();
		end_test("ball 2 hits only in the air");

		pick_standing(-1, b3);
		pick_standing(b3, b4);
		random_spot(b3, x1, y1);
		random_spot(b4, x2, y2);
		base1 = hit1_count;
		base2 = hit2_count;
		set_balls(x1, y1, 1'b1, x2, y2, 1'b1);
		pulse_frame();
		check_hits(hit1_count - base1, hit2_count - base2, 1, 1);
		tb_alive[b3] = 1'b0;
		tb_alive[b4] = 1'b0;
		check_all_blocks();
		end_test("both balls in one frame");

		base1 = hit1_count;
		base2 = hit2_count;
		set_balls(x1, y1, 1'b1, x2, y2, 1'b0);  // ball 1 still over its block
		@(posedge Clk);
		#1 before_game_flag = 1'b1;
		pulse_frame();  // event reaches the wall while it is restored
		@(posedge Clk);
		#1 before_game_flag = 1'b0;
		set_balls(x1, y1, 1'b0, x2, y2, 1'b0);
		check_hits(hit1_count - base1, hit2_count - base2, 0, 0);
		tb_alive = '1;
		check_all_blocks();
		end_test("restore before the game");

		$display("%0d tests run, %0d errors", test_count, err_count);
		if (err_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+sim
common/dewall_pkg.sv
common/hit_event_if.sv
dewall/impact_scanner.sv
dewall/hit_event_fifo.sv
dewall/block_state.sv
logic/wall_renderer.sv
dewall/dewall_field.sv
sim/tb_dewall_field.sv
